//--- Bender.yml
package:
  name: tx_lane

sources:
  - tx_lane_pkg.sv
  - ack_skid.sv
  - lane_scrambler.sv
  - lane_gearbox.sv
  - tx_lane_top.sv
  - target: test
    files:
      - tx_lane_assertions.sv
      - tb_tx_lane.sv

//--- ack_skid.sv
`timescale 1ns/1ps

// one stage of ack pipelining
// the downstream ack is registered before it goes upstream, so the upstream side
// sees the ack one cycle late and may hand over a word the downstream side did not
// ask for in that cycle, and the slush register catches that word
module ack_skid import tx_lane_pkg::*; #(
	parameter int WIDTH = WORD_W
) (
	input  logic             clk,
	input  logic             arst_n_i,

	input  logic [WIDTH-1:0] in_dat_i,
	output logic             in_ack_o,

	output logic [WIDTH-1:0] out_dat_o,
	input  logic             out_ack_i
);

	// two copies of the registered ack
	// ack_q goes upstream, ack_dp_q steers the local data registers
	logic ack_q;
	logic ack_dp_q;

	// one spare word plus its valid flag
	logic [WIDTH-1:0] slush;
	logic             slush_valid;

	assign in_ack_o = ack_q;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q       <= 1'b0;
			ack_dp_q    <= 1'b0;
			slush_valid <= 1'b0;
			// the chain flushes zero words after reset, so data starts cleared
			slush       <= '0;
			out_dat_o   <= '0;
		end else begin
			ack_q    <= out_ack_i;
			ack_dp_q <= out_ack_i;

			if (ack_dp_q) begin
				// upstream hands over in_dat_i in this cycle
				if (out_ack_i) begin
					// downstream takes out_dat_o too, so the stream moves on by one
					if (slush_valid) begin
						// oldest word first, the new word waits in slush
						out_dat_o <= slush;
						slush     <= in_dat_i;
					end else begin
						out_dat_o <= in_dat_i;
					end
				end else begin
					// back-pressure case, park the word
					slush       <= in_dat_i;
					slush_valid <= 1'b1;
				end
			end else begin
				// nothing arrives from upstream in this cycle
				if (out_ack_i) begin
					// drain slush into the output register
					// with no valid slush this re-presents the stale slush word,
					// which is how the zero flush words appear after reset
					out_dat_o   <= slush;
					slush_valid <= 1'b0;
				end
				// otherwise the output word simply holds
			end
		end
	end

endmodule

//--- all.f
tx_lane_pkg.sv
ack_skid.sv
lane_scrambler.sv
lane_gearbox.sv
tx_lane_top.sv
tx_lane_assertions.sv
tb_tx_lane.sv

//--- lane_gearbox.sv
`timescale 1ns/1ps

// 64 to 40 bit gearbox
// bits are kept in a shift buffer with the oldest bit at index 0
// each cycle the low 40 bits leave when at least 40 are held, and a new
// 64-bit word is appended above the remainder whenever that remainder
// falls below 40, which is exactly the cycle in which ack_o is high
module lane_gearbox import tx_lane_pkg::*; (
	input  logic              clk,
	input  logic              arst_n_i,

	input  logic [WORD_W-1:0] word_i,
	output logic              ack_o,

	output logic [LANE_W-1:0] lane_o,
	output logic              lane_valid_o
);

	// the remainder is at most LANE_W-1 bits when a word is appended,
	// so the fill never exceeds LANE_W+WORD_W-1 = 103
	localparam int BUF_W  = LANE_W + WORD_W;
	localparam int FILL_W = $clog2(BUF_W);

	// buffered bits, valid below fill, zero above it
	logic [BUF_W-1:0]  bit_buf;
	logic [FILL_W-1:0] fill;

	// this cycle's decisions
	logic              take_out;
	logic [FILL_W-1:0] rem;
	logic [BUF_W-1:0]  rem_bits;
	logic [BUF_W-1:0]  buf_nxt;
	logic [FILL_W-1:0] fill_nxt;

	always_comb begin
		// a lane word leaves whenever a full one is buffered
		take_out = (fill >= FILL_W'(LANE_W));

		if (take_out) begin
			rem      = fill - FILL_W'(LANE_W);
			rem_bits = bit_buf >> LANE_W;
		end else begin
			rem      = fill;
			rem_bits = bit_buf;
		end

		// ask for a word when what is left cannot fill the next lane word
		// the word on word_i is taken in this same cycle
		ack_o = (rem < FILL_W'(LANE_W));

		buf_nxt  = rem_bits;
		fill_nxt = rem;
		if (ack_o) begin
			// new word goes directly above the remaining bits, keeping LSB-first order
			buf_nxt  = rem_bits | (BUF_W'(word_i) << rem);
			fill_nxt = rem + FILL_W'(WORD_W);
		end
	end

	// starting empty the fill runs 0, 64, 88, 48, 72, 96, 56, 80, 40 and then
	// repeats from 64 with five acks in every eight cycles
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bit_buf      <= '0;
			fill         <= '0;
			lane_o       <= '0;
			lane_valid_o <= 1'b0;
		end else begin
			bit_buf <= buf_nxt;
			fill    <= fill_nxt;

			// lane_o carries the bits selected one cycle earlier
			if (take_out) begin
				lane_o <= bit_buf[LANE_W-1:0];
			end

			// only the empty start-up cycle has no output, so once high this stays high
			lane_valid_o <= take_out;
		end
	end

endmodule

//--- lane_scrambler.sv
`timescale 1ns/1ps

// self-synchronous scrambler, polynomial x^58 + x^39 + 1
// the word is scrambled bit-serially with bit 0 first in time, and every
// scrambled bit is fed back as history for the bits that follow it
module lane_scrambler import tx_lane_pkg::*; (
	input  logic              clk,
	input  logic              arst_n_i,

	input  logic [WORD_W-1:0] word_i,
	input  logic              take_i,
	output logic [WORD_W-1:0] scr_o
);

	// lag of the middle tap
	localparam int TAP_LAG = 39;

	// last SCRAM_W scrambled bits in time order
	// state[SCRAM_W-1] is the most recent bit, state[0] the one at lag 58
	logic [SCRAM_W-1:0] state;

	// history followed by the new word's scrambled bits, oldest at index 0
	// scrambled bit i sits at index SCRAM_W+i, so its lag-58 bit is at index i
	// and its lag-39 bit is at index i+SCRAM_W-TAP_LAG
	logic [SCRAM_W+WORD_W-1:0] ext;

	always_comb begin
		ext[SCRAM_W-1:0] = state;
		for (int i = 0; i < WORD_W; i++) begin
			ext[SCRAM_W+i] = word_i[i] ^ ext[i+SCRAM_W-TAP_LAG] ^ ext[i];
		end
	end

	// output is purely combinational and always belongs to the word on word_i
	assign scr_o = ext[SCRAM_W +: WORD_W];

	// the newest SCRAM_W bits become the history once the word is taken
	// a word that is presented but not taken leaves the state alone
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state <= SCRAM_SEED;
		end else if (take_i) begin
			state <= ext[WORD_W +: SCRAM_W];
		end
	end

endmodule

//--- tb_tx_lane.sv
`timescale 1ns/1ps

// testbench for the transmit lane slice
// the source replays the stim words under the DUT's ack, the lane output is
// reassembled into 64-bit words and compared with the scrambled words that
// the stim file lists next to each input word
module tb_tx_lane import tx_lane_pkg::*; ();

	localparam int NUM_SKID       = DEF_NUM_SKID;
	localparam int NUM_WORDS      = 24;
	localparam int RESET_CYCLES   = 16;
	// zero words that the skid chain may flush out ahead of the first real word
	localparam int MAX_FLUSH      = 2 * NUM_SKID + 2;
	// the gearbox takes 5 words in 8 cycles, plus pipeline fill and some margin
	localparam int TIMEOUT_CYCLES = (NUM_WORDS * 8 / 5) + 4 * NUM_SKID + 64;
	// holds a partial word plus one more lane word
	localparam int ACC_W          = 2 * WORD_W;

	logic              clk;
	logic              arst_n_i;
	logic [WORD_W-1:0] word_i;
	logic              word_ack_o;
	logic [LANE_W-1:0] lane_o;
	logic              lane_valid_o;

	// even entries are input words, odd entries the expected scrambled words
	logic [WORD_W-1:0] stim_mem [0:2*NUM_WORDS-1];

	// source state
	int   src_idx  = 0;
	logic ack_seen = 1'b0;

	// monitor state
	int               cycle_cnt     = 0;
	int               valid_cycles  = 0;
	logic [7:0]       ack_hist      = '0;
	logic [ACC_W-1:0] bit_acc       = '0;
	int               acc_fill      = 0;
	int               flush_words   = 0;
	logic             data_seen     = 1'b0;
	int               words_checked = 0;

	tx_lane_top #(
		.NUM_SKID (NUM_SKID)
	) DUT (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.word_i       (word_i),
		.word_ack_o   (word_ack_o),
		.lane_o       (lane_o),
		.lane_valid_o (lane_valid_o)
	);

	// the gearbox fill is internal, so it is picked up through the hierarchy
	bind tx_lane_top tx_lane_assertions #(
		.NUM_SKID (NUM_SKID)
	) u_assertions (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.skid_ack_i   (skid_ack),
		.gb_fill_i    (u_gearbox.fill),
		.lane_valid_i (lane_valid_o)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	// a word counts as a pacing check when an earlier line has the same input
	// word but a different scrambled word, which needs a moving scrambler state
	function automatic string word_test_name(input int idx);
		string name;
		name = "bitstream";
		for (int j = 0; j < idx; j++) begin
			if (stim_mem[2*j] == stim_mem[2*idx] &&
				stim_mem[2*j+1] != stim_mem[2*idx+1]) begin
				name = "scrambler_pacing";
			end
		end
		return name;
	endfunction

	task automatic check_reset_outputs();
		assert (!word_ack_o && !lane_valid_o) else
			abort_run($sformatf(
				"CHECK FAILED: reset_state expected ack=0 valid=0 actual ack=%0b valid=%0b",
				word_ack_o, lane_valid_o));
	endtask

	// in steady state every eight cycles of word_ack_o hold five acks
	task automatic check_ack_rate();
		int ones;
		ack_hist = {ack_hist[6:0], word_ack_o};
		if (lane_valid_o) begin
			valid_cycles++;
		end
		// the window must also clear the cycles of ack delay in the chain
		if (valid_cycles >= 8 + NUM_SKID) begin
			ones = 0;
			for (int i = 0; i < 8; i++) begin
				ones += ack_hist[i];
			end
			assert (ones == 5) else
				abort_run($sformatf("CHECK FAILED: ack_rate expected 5 actual %0d (window %b)",
					ones, ack_hist));
		end
	endtask

	task automatic check_stream_word(input logic [WORD_W-1:0] word);
		logic [WORD_W-1:0] expected;
		string             name;
		if (!data_seen && word == '0) begin
			// still in the zero words flushed out of the skid chain
			flush_words++;
			assert (flush_words <= MAX_FLUSH) else
				abort_run($sformatf("more than %0d zero words came out before the first data word",
					MAX_FLUSH));
		end else if (words_checked < NUM_WORDS) begin
			data_seen = 1'b1;
			expected  = stim_mem[2*words_checked+1];
			name      = word_test_name(words_checked);
			assert (word === expected) else
				abort_run($sformatf("CHECK FAILED: %s word %0d expected %h actual %h",
					name, words_checked, expected, word));
			words_checked++;
		end
	endtask

	// lane words are appended LSB first, each full 64 bits is one stream word
	task automatic collect_lane_word(input logic [LANE_W-1:0] lane);
		logic [WORD_W-1:0] word;
		bit_acc  = bit_acc | (ACC_W'(lane) << acc_fill);
		acc_fill = acc_fill + LANE_W;
		if (acc_fill >= WORD_W) begin
			word     = bit_acc[WORD_W-1:0];
			bit_acc  = bit_acc >> WORD_W;
			acc_fill = acc_fill - WORD_W;
			check_stream_word(word);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		int pacing_words;
		$readmemh("tx_lane_stim.txt", stim_mem);
		arst_n_i = 1'b0;
		word_i   = stim_mem[0];

		assert (!$isunknown(stim_mem[2*NUM_WORDS-1])) else
			abort_run($sformatf("stim file is missing or holds fewer than %0d lines", NUM_WORDS));
		// a zero first word could not be told apart from the flush words
		assert (stim_mem[1] != '0) else
			abort_run("first expected word in the stim file is zero");
		pacing_words = 0;
		for (int i = 0; i < NUM_WORDS; i++) begin
			if (word_test_name(i) == "scrambler_pacing") begin
				pacing_words++;
			end
		end
		assert (pacing_words > 0) else
			abort_run("stim file has no repeated input word with a different scrambled word");

		repeat (RESET_CYCLES) @(posedge clk);
		arst_n_i <= 1'b1;
	end

	// the source never withholds data and moves on after every acked cycle
	always @(posedge clk) begin
		if (arst_n_i && ack_seen) begin
			src_idx <= src_idx + 1;
			if (src_idx + 1 < NUM_WORDS) begin
				word_i <= stim_mem[2*(src_idx+1)];
			end else begin
				word_i <= '0;
			end
		end
	end

	// outputs are sampled half a cycle after the edge that set them
	always @(negedge clk) begin
		ack_seen = word_ack_o;
		if (!arst_n_i) begin
			check_reset_outputs();
		end else begin
			if (cycle_cnt == 0) begin
				check_reset_outputs();
			end
			cycle_cnt++;
			check_ack_rate();
			if (lane_valid_o) begin
				collect_lane_word(lane_o);
			end
			if (words_checked == NUM_WORDS) begin
				$display("TEST PASSED");
				$finish;
			end else if (cycle_cnt >= TIMEOUT_CYCLES) begin
				abort_run($sformatf("timeout after %0d cycles with %0d of %0d words seen",
					cycle_cnt, words_checked, NUM_WORDS));
			end
		end
	end

endmodule

//--- tx_lane_assertions.sv
`timescale 1ns/1ps

// concurrent checks on the ack chain and the gearbox, bound into tx_lane_top
module tx_lane_assertions import tx_lane_pkg::*; #(
	parameter int NUM_SKID = DEF_NUM_SKID
) (
	input logic                            clk,
	input logic                            arst_n_i,
	input logic                            skid_ack_i [NUM_SKID+1],
	input logic [$clog2(LANE_W+WORD_W)-1:0] gb_fill_i,
	input logic                            lane_valid_i
);

	// every stage hands its downstream ack upstream exactly one cycle later
	// the cycle right after reset is skipped since the registers were still held then
	for (genvar k = 0; k < NUM_SKID; k++) begin : g_ack_delay
		a_ack_delay : assert property (@(posedge clk) disable iff (!arst_n_i)
			$past(arst_n_i) |-> (skid_ack_i[k] == $past(skid_ack_i[k+1])))
			else $error("skid stage %0d ack is not its downstream ack delayed by one cycle", k);
	end

	// the gearbox only appends a word to a remainder below 40 bits
	a_fill_limit : assert property (@(posedge clk) disable iff (!arst_n_i)
		gb_fill_i <= (LANE_W + WORD_W - 1))
		else $error("gearbox fill %0d is above %0d bits", gb_fill_i, LANE_W + WORD_W - 1);

	// once primed the gearbox emits a lane word every cycle
	a_valid_stays : assert property (@(posedge clk) disable iff (!arst_n_i)
		lane_valid_i |=> lane_valid_i)
		else $error("lane_valid_o fell after it had risen");

endmodule

//--- tx_lane_pkg.sv
// shared widths and constants for the transmit lane slice
package tx_lane_pkg;

	// width of one data word entering the lane
	localparam int WORD_W = 64;

	// width of one lane word leaving the gearbox
	localparam int LANE_W = 40;

	// scrambler state length, one bit per lag of the x^58 term
	localparam int SCRAM_W = 58;

	// scrambler state after reset, all ones so the first words are never trivially zero
	localparam logic [SCRAM_W-1:0] SCRAM_SEED = {SCRAM_W{1'b1}};

	// default depth of the ack skid chain between scrambler and gearbox
	localparam int DEF_NUM_SKID = 3;

endpackage

//--- tx_lane_stim.txt
// column 1: input word in hex, column 2: expected scrambled word in hex
// the scrambler starts from the all-ones seed before the first line
0000000000000000 03FFFF8000000000
0000000000000000 FFEFFFFFFFFFC000
FFFFBFFFF7FFFF00 FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
03FFFF8000000000 0000000000000000
0000000000000000 0000000000000000
FC00007FFFFFFFFF FFFFFFFFFFFFFFFF
0000000000000000 03FFFF8000000000
0000000000000000 FFEFFFFFFFFFC000
FFFFBFFFF7FFFF00 FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
03FFFF8000000000 0000000000000000
FC00007FFFFFFFFF FFFFFFFFFFFFFFFF
03FFFF8000000000 0000000000000000
0000000000000000 0000000000000000
0000000000000000 0000000000000000
FC00007FFFFFFFFF FFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF
0000000000000000 03FFFF8000000000
0000000000000000 FFEFFFFFFFFFC000
FFFFBFFFF7FFFF00 FFFFFFFFFFFFFFFF
03FFFF8000000000 0000000000000000
FC00007FFFFFFFFF FFFFFFFFFFFFFFFF
03FFFF8000000000 0000000000000000

//--- tx_lane_top.sv
`timescale 1ns/1ps

// transmit lane slice
// word_i goes through the scrambler, a chain of NUM_SKID ack skid stages and
// the gearbox, and the gearbox ack travels back through the chain so that
// word_ack_o is the gearbox ack delayed by NUM_SKID cycles
module tx_lane_top import tx_lane_pkg::*; #(
	parameter int NUM_SKID = DEF_NUM_SKID
) (
	input  logic              clk,
	input  logic              arst_n_i,

	input  logic [WORD_W-1:0] word_i,
	output logic              word_ack_o,

	output logic [LANE_W-1:0] lane_o,
	output logic              lane_valid_o
);

	// scrambled word, valid for whatever the source currently presents
	logic [WORD_W-1:0] scr_word;

	// ack generated by the gearbox
	logic gb_ack;

	// skid chain boundaries
	// index 0 faces the scrambler, index NUM_SKID faces the gearbox
	logic [WORD_W-1:0] skid_dat [NUM_SKID+1];
	logic              skid_ack [NUM_SKID+1];

	assign skid_dat[0]        = scr_word;
	assign skid_ack[NUM_SKID] = gb_ack;

	// stage 0 acks the source, and the same ack advances the scrambler state
	assign word_ack_o = skid_ack[0];

	lane_scrambler u_scrambler (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.word_i   (word_i),
		.take_i   (skid_ack[0]),
		.scr_o    (scr_word)
	);

	// each stage adds one register of ack latency
	for (genvar k = 0; k < NUM_SKID; k++) begin : g_skid
		ack_skid #(
			.WIDTH (WORD_W)
		) u_skid (
			.clk       (clk),
			.arst_n_i  (arst_n_i),
			.in_dat_i  (skid_dat[k]),
			.in_ack_o  (skid_ack[k]),
			.out_dat_o (skid_dat[k+1]),
			.out_ack_i (skid_ack[k+1])
		);
	end

	lane_gearbox u_gearbox (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.word_i       (skid_dat[NUM_SKID]),
		.ack_o        (gb_ack),
		.lane_o       (lane_o),
		.lane_valid_o (lane_valid_o)
	);

endmodule
